//--- fetch_pkg.sv
package fetch_pkg;

	// L1.5 return types, 4 bit field
	localparam logic [3:0] ret_load   = 4'b0000;
	localparam logic [3:0] ret_ifill  = 4'b0001;
	localparam logic [3:0] ret_st_ack = 4'b0100;
	localparam logic [3:0] ret_int    = 4'b0111; // boot wake-up comes in as this
	localparam logic [3:0] ret_err    = 4'b1100;

	// request side codes
	localparam logic [4:0] rq_imiss = 5'b10000; // instruction miss
	localparam logic [2:0] rq_size  = 3'b101;   // 16 byte block

	// add x0, x0, x0
	localparam logic [31:0] instr_nop = 32'h00000033;

	// request machine states
	typedef enum logic [1:0]
	{
		st_req      = 2'd0,
		st_wait_ack = 2'd1,
		st_resp     = 2'd2
	} fetch_state_t;

endpackage

//--- fetch_pc_gen.sv
`timescale 1ns/1ps

module fetch_pc_gen import fetch_pkg::*;
#(
	parameter logic [31:0] reset_pc = 32'h40000000
)
(
	input  logic         clk,
	input  logic         nrst,
	input  logic [1:0]   pcsel,
	input  logic [31:0]  target,
	input  logic [31:0]  epc,
	input  logic         exception_pending,
	input  fetch_state_t fetch_state,
	input  logic         resp_fire,
	output logic [31:0]  fetch_pc,
	output logic [31:0]  pc2,
	output logic         kill
);

	logic [31:0] next_pc;
	logic [31:0] saved_pc;    // redirect address held while a fetch is out
	logic [31:0] redirect_pc;
	logic        redirect;    // branch or exception
	logic        req_update;  // anything that moves fetch_pc before acceptance

	assign redirect    = exception_pending || (pcsel == 2'd2);
	assign redirect_pc = exception_pending ? epc : target;
	assign req_update  = redirect || (pcsel == 2'd1);

	// priority: saved redirect, exception, branch, reset vector, hold, sequential
	always_comb
	begin
		if (kill)
			next_pc = saved_pc;
		else if (exception_pending)
			next_pc = epc;
		else
		begin
			case (pcsel)
				2'd1:    next_pc = reset_pc;
				2'd2:    next_pc = target;
				2'd3:    next_pc = fetch_pc;
				default: next_pc = fetch_pc + 32'd4;
			endcase
		end
	end

	// saved address, valid while kill is set
	always_ff @(posedge clk)
	begin
		if (!resp_fire && redirect && fetch_state != st_req)
			saved_pc <= redirect_pc;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			fetch_pc <= reset_pc;
			pc2      <= reset_pc;
			kill     <= 1'b0;
		end
		else if (resp_fire)
		begin
			fetch_pc <= next_pc;
			kill     <= 1'b0;
			if (!kill)
				pc2 <= fetch_pc; // dropped fetch leaves pc2 alone
		end
		else if (fetch_state == st_req)
		begin
			// nothing in flight yet, so just move the address
			if (req_update)
				fetch_pc <= next_pc;
		end
		else if (redirect)
		begin
			kill <= 1'b1; // fetch in flight is now stale
		end
	end

endmodule

//--- fetch_l15_port.sv
`timescale 1ns/1ps

module fetch_l15_port import fetch_pkg::*;
(
	input  logic         clk,
	input  logic         nrst,
	input  logic         stall,
	input  logic [31:0]  fetch_pc,

	// request channel
	input  logic         l15_transducer_header_ack,
	input  logic         l15_transducer_ack,
	output logic         transducer_l15_val,
	output logic [4:0]   transducer_l15_rqtype,
	output logic [2:0]   transducer_l15_size,
	output logic [31:0]  transducer_l15_address,

	// response channel
	input  logic         l15_transducer_val,
	input  logic [3:0]   l15_transducer_returntype,
	output logic         transducer_l15_req_ack,

	output fetch_state_t fetch_state,
	output logic         resp_fire,
	output logic         awake
);

	fetch_state_t state_next;
	logic         req_fire;
	logic         fetch_ret;  // return type that carries instruction data
	logic         other_ret;  // anything else, acked and dropped

	// wake-up latch, set by the first interrupt return
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			awake <= 1'b0;
		else if (l15_transducer_val && l15_transducer_returntype == ret_int)
			awake <= 1'b1;
	end

	assign fetch_ret = (l15_transducer_returntype == ret_ifill) ||
		(l15_transducer_returntype == ret_load);
	assign other_ret = l15_transducer_val && !fetch_ret;

	// request fields
	assign transducer_l15_val     = (fetch_state == st_req) && awake && !stall;
	assign transducer_l15_rqtype  = rq_imiss;
	assign transducer_l15_size    = rq_size;
	assign transducer_l15_address = fetch_pc;

	assign req_fire  = transducer_l15_val && l15_transducer_header_ack;
	assign resp_fire = (fetch_state == st_resp) && l15_transducer_val && fetch_ret;

	assign transducer_l15_req_ack = resp_fire || other_ret;

	always_comb
	begin
		state_next = fetch_state;
		case (fetch_state)
			st_req:
			begin
				if (req_fire)
					state_next = l15_transducer_ack ? st_resp : st_wait_ack;
			end
			st_wait_ack:
			begin
				if (l15_transducer_ack)
					state_next = st_resp;
			end
			st_resp:
			begin
				if (resp_fire)
					state_next = st_req;
			end
			default:
			begin
				state_next = st_req;
			end
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			fetch_state <= st_req;
		else
			fetch_state <= state_next;
	end

endmodule

//--- fetch_word_select.sv
`timescale 1ns/1ps

module fetch_word_select import fetch_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  logic        resp_fire,
	input  logic        kill,
	input  logic [31:0] fetch_pc,
	input  logic [63:0] l15_transducer_data_0,
	input  logic [63:0] l15_transducer_data_1,
	output logic [31:0] instr2,
	output logic        instr_val
);

	logic [31:0] word;
	logic [31:0] word_le;

	// pick the word within the 16 byte block
	always_comb
	begin
		case (fetch_pc[3:2])
			2'd0:    word = l15_transducer_data_0[63:32];
			2'd1:    word = l15_transducer_data_0[31:0];
			2'd2:    word = l15_transducer_data_1[63:32];
			default: word = l15_transducer_data_1[31:0];
		endcase
	end

	// cache returns big endian bytes
	assign word_le = {word[7:0], word[15:8], word[23:16], word[31:24]};

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			instr2    <= instr_nop;
			instr_val <= 1'b0;
		end
		else
		begin
			instr_val <= resp_fire && !kill;
			if (resp_fire)
				instr2 <= kill ? instr_nop : word_le;
		end
	end

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import fetch_pkg::*;
#(
	parameter logic [31:0] reset_pc = 32'h40000000
)
(
	input  logic        clk,
	input  logic        nrst,

	// core side
	input  logic [1:0]  pcsel,
	input  logic [31:0] target,
	input  logic        exception_pending,
	input  logic [31:0] epc,
	input  logic        stall,
	output logic [31:0] pc2,
	output logic [31:0] instr2,
	output logic        instr_val,

	// L1.5 request
	output logic        transducer_l15_val,
	output logic [4:0]  transducer_l15_rqtype,
	output logic [2:0]  transducer_l15_size,
	output logic [31:0] transducer_l15_address,
	input  logic        l15_transducer_header_ack,
	input  logic        l15_transducer_ack,

	// L1.5 response
	input  logic        l15_transducer_val,
	input  logic [3:0]  l15_transducer_returntype,
	input  logic [63:0] l15_transducer_data_0,
	input  logic [63:0] l15_transducer_data_1,
	output logic        transducer_l15_req_ack
);

	fetch_state_t fetch_state;
	logic         resp_fire;
	logic         awake;
	logic [31:0]  fetch_pc;
	logic         kill;

	fetch_pc_gen #(
		.reset_pc (reset_pc)
	) pc_gen0 (
		.clk               (clk),
		.nrst              (nrst),
		.pcsel             (pcsel),
		.target            (target),
		.epc               (epc),
		.exception_pending (exception_pending && awake), // no redirects before boot
		.fetch_state       (fetch_state),
		.resp_fire         (resp_fire),
		.fetch_pc          (fetch_pc),
		.pc2               (pc2),
		.kill              (kill)
	);

	fetch_l15_port l15_port0 (
		.clk                       (clk),
		.nrst                      (nrst),
		.stall                     (stall),
		.fetch_pc                  (fetch_pc),
		.l15_transducer_header_ack (l15_transducer_header_ack),
		.l15_transducer_ack        (l15_transducer_ack),
		.transducer_l15_val        (transducer_l15_val),
		.transducer_l15_rqtype     (transducer_l15_rqtype),
		.transducer_l15_size       (transducer_l15_size),
		.transducer_l15_address    (transducer_l15_address),
		.l15_transducer_val        (l15_transducer_val),
		.l15_transducer_returntype (l15_transducer_returntype),
		.transducer_l15_req_ack    (transducer_l15_req_ack),
		.fetch_state               (fetch_state),
		.resp_fire                 (resp_fire),
		.awake                     (awake)
	);

	fetch_word_select word_sel0 (
		.clk                   (clk),
		.nrst                  (nrst),
		.resp_fire             (resp_fire),
		.kill                  (kill),
		.fetch_pc              (fetch_pc),
		.l15_transducer_data_0 (l15_transducer_data_0),
		.l15_transducer_data_1 (l15_transducer_data_1),
		.instr2                (instr2),
		.instr_val             (instr_val)
	);

endmodule

//--- tb_fetch_stage.sv
`timescale 1ns/1ps

module tb_fetch_stage import fetch_pkg::*;
();

	localparam logic [31:0] reset_pc = 32'h40000000;

	logic        clk;
	logic        nrst;
	logic [1:0]  pcsel;
	logic [31:0] target;
	logic [31:0] epc;
	logic        exception_pending;
	logic        stall;
	logic [31:0] pc2;
	logic [31:0] instr2;
	logic        instr_val;
	logic        transducer_l15_val;
	logic [4:0]  transducer_l15_rqtype;
	logic [2:0]  transducer_l15_size;
	logic [31:0] transducer_l15_address;
	logic        l15_transducer_header_ack;
	logic        l15_transducer_ack;
	logic        l15_transducer_val;
	logic [3:0]  l15_transducer_returntype;
	logic [63:0] l15_transducer_data_0;
	logic [63:0] l15_transducer_data_1;
	logic        transducer_l15_req_ack;

	integer      seed = 32'h469e;
	int          mismatches = 0;
	int          failures = 0;
	logic        timed_out = 1'b0;
	logic        booted = 1'b0;       // ret_int already returned
	logic        deliver_due = 1'b0;  // instr_val expected in the coming sample
	logic [31:0] exp_pc = reset_pc;   // next request address
	logic [31:0] exp_pc2 = reset_pc;
	logic [31:0] exp_instr = instr_nop;

	fetch_stage #(.reset_pc(reset_pc)) dut0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic int urand(input int n);
		return {$random(seed)} % n;
	endfunction

	// responder memory image, every word a function of its address
	function automatic logic [31:0] model_word(input logic [31:0] addr);
		return ({addr[31:4], 4'h0} ^ 32'h9e3779b9) + {30'h0, addr[3:2]} * 32'h01030507;
	endfunction

	function automatic logic [31:0] byte_rev(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic logic [3:0] other_type();
		case (urand(3))
			0:       return ret_st_ack;
			1:       return ret_err;
			default: return ret_int;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp)
		else
		begin
			mismatches++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		failures++;
		$display("error: %s", what);
	endtask

	// pulses drop back low unless the caller drives them again
	task automatic begin_cycle();
		@(posedge clk);
		pcsel <= 2'd0;
		exception_pending <= 1'b0;
		l15_transducer_header_ack <= 1'b0;
		l15_transducer_ack <= 1'b0;
		l15_transducer_val <= 1'b0;
	endtask

	task automatic end_cycle();
		@(negedge clk);
		if (!booted)
		begin
			assert (!transducer_l15_val)
			else
				report_failure("fetch request issued before the wake-up return");
		end
		check_value("instr_val", 32'(instr_val), 32'(deliver_due));
		check_value("pc2", pc2, exp_pc2);
		check_value("instr2", instr2, exp_instr); // only moves on a response
		deliver_due = 1'b0;
	endtask

	task automatic idle_cycle();
		begin_cycle();
		end_cycle();
	endtask

	task automatic check_request();
		assert (transducer_l15_val)
		else
			report_failure("no fetch request where one was due");
		check_value("transducer_l15_address", transducer_l15_address, exp_pc);
		check_value("transducer_l15_rqtype", 32'(transducer_l15_rqtype), 32'(rq_imiss));
		check_value("transducer_l15_size", 32'(transducer_l15_size), 32'(rq_size));
	endtask

	// mode 0 plain, 1 killed by branch, 2 killed by exception, 3 redirect before the request
	task automatic do_fetch(input int mode, input logic hold);
		logic [31:0] addr;
		logic [31:0] redir;
		logic [31:0] decoy;
		int n;
		int total;
		int kill_at;
		int junk_at;
		int ack_delay;
		redir = {$random(seed)} & 32'hfffffffc;
		decoy = ~redir & 32'hfffffffc; // never equals redir
		ack_delay = urand(4);
		total = ack_delay + urand(4) + 1;
		kill_at = (mode == 1 || mode == 2) ? urand(total) + 1 : -1;
		junk_at = urand(2 * total) + 1; // past total means no stray return
		if (mode == 3)
		begin
			n = urand(3);
			begin_cycle();
			pcsel <= (n == 0) ? 2'd2 : (n == 1) ? 2'd1 : 2'd0;
			exception_pending <= (n == 2);
			target <= (n == 2) ? decoy : redir;
			epc <= (n == 2) ? redir : decoy;
			end_cycle();
			exp_pc = (n == 1) ? reset_pc : redir;
			idle_cycle(); // fetch_pc moved on that edge
		end
		n = 0;
		while (!transducer_l15_val && n < 40)
		begin
			idle_cycle();
			n++;
		end
		assert (transducer_l15_val)
		else
		begin
			timed_out = 1'b1;
			report_failure("timed out waiting for a fetch request");
		end
		if (timed_out)
			return;
		check_request();
		addr = exp_pc;
		repeat (urand(3))
			idle_cycle();   // header ack held off
		begin_cycle();
		l15_transducer_header_ack <= 1'b1;
		l15_transducer_ack <= (ack_delay == 0);
		end_cycle();
		for (n = 1; n <= total; n++)
		begin
			begin_cycle();
			stall <= hold;
			l15_transducer_ack <= (n == ack_delay);
			if (n == kill_at)
			begin
				pcsel <= (mode == 1) ? 2'd2 : 2'd0;
				exception_pending <= (mode == 2);
				target <= (mode == 2) ? decoy : redir;
				epc <= (mode == 2) ? redir : decoy;
			end
			if (n == junk_at)
			begin
				l15_transducer_val <= 1'b1;
				l15_transducer_returntype <= other_type();
			end
			end_cycle();
			if (n == junk_at)
				check_value("transducer_l15_req_ack", 32'(transducer_l15_req_ack), 32'd1);
		end
		begin_cycle();
		l15_transducer_val <= 1'b1;
		l15_transducer_returntype <= (urand(2) == 0) ? ret_ifill : ret_load;
		l15_transducer_data_0 <= {model_word({addr[31:4], 4'h0}), model_word({addr[31:4], 4'h4})};
		l15_transducer_data_1 <= {model_word({addr[31:4], 4'h8}), model_word({addr[31:4], 4'hc})};
		end_cycle();
		check_value("transducer_l15_req_ack", 32'(transducer_l15_req_ack), 32'd1);
		deliver_due = (kill_at < 0);
		exp_pc2 = deliver_due ? addr : exp_pc2;
		exp_instr = deliver_due ? byte_rev(model_word(addr)) : instr_nop;
		exp_pc = deliver_due ? addr + 32'd4 : redir;
		idle_cycle();
		check_value("transducer_l15_val", 32'(transducer_l15_val), 32'(!hold));
		if (hold)
		begin
			repeat (urand(3))
			begin
				idle_cycle();
				check_value("transducer_l15_val", 32'(transducer_l15_val), 32'd0);
			end
			begin_cycle();
			stall <= 1'b0;
			end_cycle();
		end
		check_request();
	endtask

	initial
	begin
		int i;
		int m;
		nrst = 1'b0;
		pcsel = 2'd0;
		target = 32'h0;
		epc = 32'h0;
		exception_pending = 1'b0;
		stall = 1'b0;
		l15_transducer_header_ack = 1'b0;
		l15_transducer_ack = 1'b0;
		l15_transducer_val = 1'b0;
		l15_transducer_returntype = ret_load;
		l15_transducer_data_0 = 64'h0;
		l15_transducer_data_1 = 64'h0;
		repeat (2)
			@(posedge clk);
		nrst <= 1'b1;
		end_cycle();
		check_value("transducer_l15_req_ack", 32'(transducer_l15_req_ack), 32'd0);
		repeat (urand(6) + 2)
			idle_cycle();
		begin_cycle();
		l15_transducer_val <= 1'b1;
		l15_transducer_returntype <= ret_st_ack; // stray return before boot
		end_cycle();
		check_value("transducer_l15_req_ack", 32'(transducer_l15_req_ack), 32'd1);
		begin_cycle();
		l15_transducer_val <= 1'b1;
		l15_transducer_returntype <= ret_int;
		end_cycle();
		check_value("transducer_l15_req_ack", 32'(transducer_l15_req_ack), 32'd1);
		booted = 1'b1;
		idle_cycle();
		check_request(); // first request at the reset vector
		for (i = 0; i < 100 && !timed_out; i++)
		begin
			m = urand(7);
			do_fetch((m > 3) ? 0 : m, urand(5) == 0);
		end
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- build.f
fetch_pkg.sv
fetch_pc_gen.sv
fetch_l15_port.sv
fetch_word_select.sv
fetch_stage.sv
tb_fetch_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_stage
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
